// File: design/rvfi_commit_pack.sv
// Commit packer
// Builds the trace record from the commit probes and the shadow table entry,
// and raises the push strobe for the output buffer

module rvfi_commit_pack (
  input  logic                        commit_valid_i,
  input  logic                        commit_ack_i,
  input  logic [rvfi_pkg::XLEN-1:0]   commit_pc_i,
  input  logic [4:0]                  commit_rs1_addr_i,
  input  logic [4:0]                  commit_rs2_addr_i,
  input  logic [4:0]                  commit_rd_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]   commit_result_i,
  input  logic [rvfi_pkg::XLEN-1:0]   commit_wdata_i,
  input  logic                        ex_valid_i,
  input  rvfi_pkg::exc_cause_e        ex_cause_i,
  input  rvfi_pkg::priv_lvl_e         priv_lvl_i,
  input  logic                        debug_mode_i,
  // Shadow table entry at the commit pointer
  input  logic [31:0]                 sb_instr_i,
  input  logic [rvfi_pkg::XLEN-1:0]   sb_rs1_i,
  input  logic [rvfi_pkg::XLEN-1:0]   sb_rs2_i,
  input  logic [rvfi_pkg::XLEN-1:0]   sb_mem_addr_i,
  input  logic [rvfi_pkg::XLEN/8-1:0] sb_rmask_i,
  input  logic [rvfi_pkg::XLEN/8-1:0] sb_wmask_i,
  input  logic [rvfi_pkg::XLEN-1:0]   sb_wdata_i,
  output logic                        push_o,
  output rvfi_pkg::trace_rec_t        rec_o
);

  import rvfi_pkg::*;

  logic trap;
  logic ecall;

  assign trap  = commit_valid_i && ex_valid_i;
  assign ecall = (ex_cause_i == CAUSE_ECALL_U) || (ex_cause_i == CAUSE_ECALL_S) ||
                 (ex_cause_i == CAUSE_ECALL_M);

  // One record per acked commit or per trap
  assign push_o = commit_ack_i || trap;

  always_comb begin
    rec_o.retired   = (commit_ack_i && !ex_valid_i) || (trap && ecall);
    rec_o.trap      = trap;
    rec_o.cause     = ex_cause_i;
    rec_o.mode      = debug_mode_i ? 2'd2 : priv_lvl_i;
    rec_o.insn      = sb_instr_i;
    rec_o.pc        = commit_pc_i;
    rec_o.rd_addr   = commit_rd_addr_i;
    rec_o.rd_wdata  = commit_wdata_i;
    rec_o.rs1_addr  = commit_rs1_addr_i;
    rec_o.rs2_addr  = commit_rs2_addr_i;
    rec_o.rs1_rdata = sb_rs1_i;
    rec_o.rs2_rdata = sb_rs2_i;
    rec_o.mem_addr  = sb_mem_addr_i;
    rec_o.mem_rmask = sb_rmask_i;
    rec_o.mem_wmask = sb_wmask_i;
    rec_o.mem_wdata = sb_wdata_i;
    rec_o.mem_rdata = commit_result_i;  // Load data comes back as the result
  end

endmodule

// File: design/rvfi_issue_latch.sv
// Issue latch
// Captures the fetched instruction word and holds it until issue takes it

module rvfi_issue_latch (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_instr_i,
  input  logic        fetch_compressed_i,
  input  logic        issue_ack_i,
  input  logic        flush_i,
  output logic [31:0] issue_instr_o
);

  logic        valid_q;
  logic [31:0] instr_q;
  logic        load;
  logic [31:0] fetch_word;

  // Accept when empty or when the current word leaves this cycle
  assign load = fetch_valid_i && (!valid_q || issue_ack_i);

  // Compressed words keep only their low half
  assign fetch_word = fetch_compressed_i ? {16'b0, fetch_instr_i[15:0]} : fetch_instr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= 1'b0;          // Flush beats a load
      end else if (load) begin
        valid_q <= 1'b1;
        instr_q <= fetch_word;
      end else if (issue_ack_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign issue_instr_o = instr_q;

endmodule

// File: design/rvfi_pkg.sv
// Retirement tracer package
// Widths, table and buffer sizes, probe enums and the packed trace record

package rvfi_pkg;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned NR_SB_ENTRIES = 8;
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned FIFO_DEPTH    = 4;
  localparam int unsigned FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    FU_NONE  = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2
  } fu_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [4:0] {
    CAUSE_ILLEGAL    = 5'd2,
    CAUSE_BREAKPOINT = 5'd3,
    CAUSE_ECALL_U    = 5'd8,
    CAUSE_ECALL_S    = 5'd9,
    CAUSE_ECALL_M    = 5'd11
  } exc_cause_e;

  // One retired or trapped instruction
  typedef struct packed {
    logic                  retired;
    logic                  trap;
    logic [4:0]            cause;
    logic [1:0]            mode;       // 2 means debug mode
    logic [31:0]           insn;
    logic [XLEN-1:0]       pc;
    logic [4:0]            rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN/8-1:0]     mem_rmask;
    logic [XLEN/8-1:0]     mem_wmask;
    logic [XLEN-1:0]       mem_wdata;
    logic [XLEN-1:0]       mem_rdata;
  } trace_rec_t;

endpackage

// File: design/rvfi_shadow_table.sv
// Shadow table
// Per transaction ID copy of the instruction word, source operands and
// memory access details, written at issue and annotated by the LSU

module rvfi_shadow_table (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Issue port
  input  logic                               dec_valid_i,
  input  logic                               dec_ack_i,
  input  logic                               flush_unissued_i,
  input  logic [rvfi_pkg::TRANS_ID_BITS-1:0] issue_ptr_i,
  input  logic [31:0]                        issue_instr_i,
  input  logic [rvfi_pkg::XLEN-1:0]          rs1_fwd_i,
  input  logic [rvfi_pkg::XLEN-1:0]          rs2_fwd_i,
  // LSU port
  input  rvfi_pkg::fu_op_e                   lsu_op_i,
  input  logic [rvfi_pkg::XLEN/8-1:0]        lsu_be_i,
  input  logic [rvfi_pkg::XLEN-1:0]          lsu_vaddr_i,
  input  logic [rvfi_pkg::TRANS_ID_BITS-1:0] lsu_trans_id_i,
  input  logic [rvfi_pkg::XLEN-1:0]          lsu_wdata_i,
  // Commit read port
  input  logic [rvfi_pkg::TRANS_ID_BITS-1:0] rd_ptr_i,
  output logic [31:0]                        rd_instr_o,
  output logic [rvfi_pkg::XLEN-1:0]          rd_rs1_o,
  output logic [rvfi_pkg::XLEN-1:0]          rd_rs2_o,
  output logic [rvfi_pkg::XLEN-1:0]          rd_mem_addr_o,
  output logic [rvfi_pkg::XLEN/8-1:0]        rd_rmask_o,
  output logic [rvfi_pkg::XLEN/8-1:0]        rd_wmask_o,
  output logic [rvfi_pkg::XLEN-1:0]          rd_wdata_o
);

  import rvfi_pkg::*;

  typedef struct packed {
    logic [31:0]       instr;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN/8-1:0] rmask;
    logic [XLEN/8-1:0] wmask;
    logic [XLEN-1:0]   wdata;
  } sb_entry_t;

  sb_entry_t [NR_SB_ENTRIES-1:0] mem_q, mem_n;

  // ------------------------------------------------------------------------
  // Next state, LSU annotation applied after the issue write
  // ------------------------------------------------------------------------
  always_comb begin
    mem_n = mem_q;

    if (dec_valid_i && dec_ack_i && !flush_unissued_i) begin
      mem_n[issue_ptr_i] = '{
        instr:    issue_instr_i,
        rs1:      rs1_fwd_i,
        rs2:      rs2_fwd_i,
        mem_addr: '0,
        rmask:    '0,
        wmask:    '0,
        wdata:    '0
      };
    end

    if (lsu_be_i != '0) begin
      case (lsu_op_i)
        FU_LOAD: begin
          mem_n[lsu_trans_id_i].mem_addr = lsu_vaddr_i;
          mem_n[lsu_trans_id_i].rmask    = lsu_be_i;
        end
        FU_STORE: begin
          mem_n[lsu_trans_id_i].mem_addr = lsu_vaddr_i;
          mem_n[lsu_trans_id_i].wmask    = lsu_be_i;
          mem_n[lsu_trans_id_i].wdata    = lsu_wdata_i;
        end
        default: ;                // Not a memory op
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_n;
    end
  end

  // Asynchronous read at the commit pointer
  assign rd_instr_o    = mem_q[rd_ptr_i].instr;
  assign rd_rs1_o      = mem_q[rd_ptr_i].rs1;
  assign rd_rs2_o      = mem_q[rd_ptr_i].rs2;
  assign rd_mem_addr_o = mem_q[rd_ptr_i].mem_addr;
  assign rd_rmask_o    = mem_q[rd_ptr_i].rmask;
  assign rd_wmask_o    = mem_q[rd_ptr_i].wmask;
  assign rd_wdata_o    = mem_q[rd_ptr_i].wdata;

endmodule

// File: design/rvfi_trace_fifo.sv
// Trace record buffer
// Circular FIFO with a valid/ready output; pushes while full are dropped
// and flagged in a sticky overflow bit

module rvfi_trace_fifo (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  rvfi_pkg::trace_rec_t rec_i,
  input  logic                 trace_ready_i,
  output logic                 trace_valid_o,
  output rvfi_pkg::trace_rec_t rec_o,
  output logic                 overflow_o
);

  import rvfi_pkg::*;

  trace_rec_t [FIFO_DEPTH-1:0] mem_q;
  logic [FIFO_PTR_BITS-1:0]    wr_ptr_q, rd_ptr_q;
  logic [FIFO_CNT_BITS-1:0]    count_q;
  logic                        full, pop, push_ok;

  assign full    = count_q == FIFO_CNT_BITS'(FIFO_DEPTH);
  assign pop     = trace_valid_o && trace_ready_i;
  assign push_ok = push_i && (!full || pop);  // Pop frees a slot in the same cycle

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= rec_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      if (push_i && !push_ok) overflow_o <= 1'b1;  // Sticky until reset
    end
  end

  assign trace_valid_o = count_q != '0;
  assign rec_o         = mem_q[rd_ptr_q];

endmodule

// File: design/rvfi_tracer.sv
// Retirement tracer top level
// Connects the pipeline probes to the issue latch, shadow table, commit
// packer and output buffer, and presents the record as loose ports

module rvfi_tracer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Fetch and flush
  input  logic                               fetch_valid_i,
  input  logic [31:0]                        fetch_instr_i,
  input  logic                               fetch_compressed_i,
  input  logic                               flush_i,
  input  logic                               issue_ack_i,
  // Decode and issue
  input  logic                               dec_valid_i,
  input  logic                               dec_ack_i,
  input  logic                               flush_unissued_i,
  input  logic [rvfi_pkg::TRANS_ID_BITS-1:0] issue_ptr_i,
  input  logic [rvfi_pkg::XLEN-1:0]          rs1_fwd_i,
  input  logic [rvfi_pkg::XLEN-1:0]          rs2_fwd_i,
  // LSU
  input  rvfi_pkg::fu_op_e                   lsu_op_i,
  input  logic [rvfi_pkg::XLEN/8-1:0]        lsu_be_i,
  input  logic [rvfi_pkg::XLEN-1:0]          lsu_vaddr_i,
  input  logic [rvfi_pkg::TRANS_ID_BITS-1:0] lsu_trans_id_i,
  input  logic [rvfi_pkg::XLEN-1:0]          lsu_wdata_i,
  // Commit
  input  logic                               commit_valid_i,
  input  logic                               commit_ack_i,
  input  logic [rvfi_pkg::TRANS_ID_BITS-1:0] commit_ptr_i,
  input  logic [rvfi_pkg::XLEN-1:0]          commit_pc_i,
  input  logic [4:0]                         commit_rs1_addr_i,
  input  logic [4:0]                         commit_rs2_addr_i,
  input  logic [4:0]                         commit_rd_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]          commit_result_i,
  input  logic [rvfi_pkg::XLEN-1:0]          commit_wdata_i,
  // Exception and privilege
  input  logic                               ex_valid_i,
  input  rvfi_pkg::exc_cause_e               ex_cause_i,
  input  rvfi_pkg::priv_lvl_e                priv_lvl_i,
  input  logic                               debug_mode_i,
  // Trace stream
  input  logic                               trace_ready_i,
  output logic                               trace_valid_o,
  output logic                               trace_retired_o,
  output logic                               trace_trap_o,
  output logic [4:0]                         trace_cause_o,
  output logic [1:0]                         trace_mode_o,
  output logic [31:0]                        trace_insn_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_pc_o,
  output logic [4:0]                         trace_rd_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_rd_wdata_o,
  output logic [4:0]                         trace_rs1_addr_o,
  output logic [4:0]                         trace_rs2_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_rs1_rdata_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_rs2_rdata_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_mem_addr_o,
  output logic [rvfi_pkg::XLEN/8-1:0]        trace_mem_rmask_o,
  output logic [rvfi_pkg::XLEN/8-1:0]        trace_mem_wmask_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_mem_wdata_o,
  output logic [rvfi_pkg::XLEN-1:0]          trace_mem_rdata_o,
  output logic                               overflow_o
);

  import rvfi_pkg::*;

  logic [31:0]       issue_instr;
  logic [31:0]       sb_instr;
  logic [XLEN-1:0]   sb_rs1, sb_rs2, sb_mem_addr, sb_wdata;
  logic [XLEN/8-1:0] sb_rmask, sb_wmask;
  logic              push;
  trace_rec_t        pack_rec;
  trace_rec_t        out_rec;

  // ------------------------------------------------------------------------
  // Issue side
  // ------------------------------------------------------------------------
  rvfi_issue_latch i_issue_latch (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_instr_i      (fetch_instr_i),
    .fetch_compressed_i (fetch_compressed_i),
    .issue_ack_i        (issue_ack_i),
    .flush_i            (flush_i),
    .issue_instr_o      (issue_instr)
  );

  rvfi_shadow_table i_shadow_table (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dec_valid_i      (dec_valid_i),
    .dec_ack_i        (dec_ack_i),
    .flush_unissued_i (flush_unissued_i),
    .issue_ptr_i      (issue_ptr_i),
    .issue_instr_i    (issue_instr),
    .rs1_fwd_i        (rs1_fwd_i),
    .rs2_fwd_i        (rs2_fwd_i),
    .lsu_op_i         (lsu_op_i),
    .lsu_be_i         (lsu_be_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_trans_id_i   (lsu_trans_id_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .rd_ptr_i         (commit_ptr_i),
    .rd_instr_o       (sb_instr),
    .rd_rs1_o         (sb_rs1),
    .rd_rs2_o         (sb_rs2),
    .rd_mem_addr_o    (sb_mem_addr),
    .rd_rmask_o       (sb_rmask),
    .rd_wmask_o       (sb_wmask),
    .rd_wdata_o       (sb_wdata)
  );

  // ------------------------------------------------------------------------
  // Commit side
  // ------------------------------------------------------------------------
  rvfi_commit_pack i_commit_pack (
    .commit_valid_i    (commit_valid_i),
    .commit_ack_i      (commit_ack_i),
    .commit_pc_i       (commit_pc_i),
    .commit_rs1_addr_i (commit_rs1_addr_i),
    .commit_rs2_addr_i (commit_rs2_addr_i),
    .commit_rd_addr_i  (commit_rd_addr_i),
    .commit_result_i   (commit_result_i),
    .commit_wdata_i    (commit_wdata_i),
    .ex_valid_i        (ex_valid_i),
    .ex_cause_i        (ex_cause_i),
    .priv_lvl_i        (priv_lvl_i),
    .debug_mode_i      (debug_mode_i),
    .sb_instr_i        (sb_instr),
    .sb_rs1_i          (sb_rs1),
    .sb_rs2_i          (sb_rs2),
    .sb_mem_addr_i     (sb_mem_addr),
    .sb_rmask_i        (sb_rmask),
    .sb_wmask_i        (sb_wmask),
    .sb_wdata_i        (sb_wdata),
    .push_o            (push),
    .rec_o             (pack_rec)
  );

  rvfi_trace_fifo i_trace_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .rec_i         (pack_rec),
    .trace_ready_i (trace_ready_i),
    .trace_valid_o (trace_valid_o),
    .rec_o         (out_rec),
    .overflow_o    (overflow_o)
  );

  // Record fields out to the stream ports
  assign trace_retired_o   = out_rec.retired;
  assign trace_trap_o      = out_rec.trap;
  assign trace_cause_o     = out_rec.cause;
  assign trace_mode_o      = out_rec.mode;
  assign trace_insn_o      = out_rec.insn;
  assign trace_pc_o        = out_rec.pc;
  assign trace_rd_addr_o   = out_rec.rd_addr;
  assign trace_rd_wdata_o  = out_rec.rd_wdata;
  assign trace_rs1_addr_o  = out_rec.rs1_addr;
  assign trace_rs2_addr_o  = out_rec.rs2_addr;
  assign trace_rs1_rdata_o = out_rec.rs1_rdata;
  assign trace_rs2_rdata_o = out_rec.rs2_rdata;
  assign trace_mem_addr_o  = out_rec.mem_addr;
  assign trace_mem_rmask_o = out_rec.mem_rmask;
  assign trace_mem_wmask_o = out_rec.mem_wmask;
  assign trace_mem_wdata_o = out_rec.mem_wdata;
  assign trace_mem_rdata_o = out_rec.mem_rdata;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the tracer testbench with Verilator, run it and judge the log

rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rvfi_tracer \
  -f verilog.f -o tb_rvfi_tracer > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_rvfi_tracer > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// File: testbench/tb_rvfi_model.svh
// Tracer reference model
// Mirrors the issue latch, the shadow table and the commit packing rules,
// and queues the records the output buffer should be holding

`ifndef TB_RVFI_MODEL_SVH
`define TB_RVFI_MODEL_SVH

logic              m_lat_valid;
logic [31:0]       m_lat_word;
logic [31:0]       m_instr [NR_SB_ENTRIES];
logic [XLEN-1:0]   m_rs1   [NR_SB_ENTRIES];
logic [XLEN-1:0]   m_rs2   [NR_SB_ENTRIES];
logic [XLEN-1:0]   m_addr  [NR_SB_ENTRIES];
logic [XLEN/8-1:0] m_rmask [NR_SB_ENTRIES];
logic [XLEN/8-1:0] m_wmask [NR_SB_ENTRIES];
logic [XLEN-1:0]   m_wdata [NR_SB_ENTRIES];
trace_rec_t        m_expq [$];     // Oldest record first
logic              m_overflow;

// ECALL from U, S and M mode
function automatic logic is_ecall(input logic [4:0] cause);
  return (cause == 5'd8) || (cause == 5'd9) || (cause == 5'd11);
endfunction

task automatic model_reset();
  m_lat_valid = 1'b0;
  m_lat_word  = '0;
  for (int i = 0; i < NR_SB_ENTRIES; i++) begin
    m_instr[i] = '0;
    m_rs1[i]   = '0;
    m_rs2[i]   = '0;
    m_addr[i]  = '0;
    m_rmask[i] = '0;
    m_wmask[i] = '0;
    m_wdata[i] = '0;
  end
  m_expq.delete();
  m_overflow = 1'b0;
endtask

// ---------------------------------------------------------------------------
// One clock edge, using the probe values that are applied right now
// ---------------------------------------------------------------------------
task automatic model_step();
  trace_rec_t rec;
  logic       trap;
  logic       push;
  logic       pop;
  logic       full;

  trap = commit_valid_i && ex_valid_i;
  push = commit_ack_i || trap;
  rec.retired   = (commit_ack_i && !ex_valid_i) || (trap && is_ecall(ex_cause_i));
  rec.trap      = trap;
  rec.cause     = ex_cause_i;
  rec.mode      = debug_mode_i ? 2'd2 : priv_lvl_i;
  rec.insn      = m_instr[commit_ptr_i];
  rec.pc        = commit_pc_i;
  rec.rd_addr   = commit_rd_addr_i;
  rec.rd_wdata  = commit_wdata_i;
  rec.rs1_addr  = commit_rs1_addr_i;
  rec.rs2_addr  = commit_rs2_addr_i;
  rec.rs1_rdata = m_rs1[commit_ptr_i];
  rec.rs2_rdata = m_rs2[commit_ptr_i];
  rec.mem_addr  = m_addr[commit_ptr_i];
  rec.mem_rmask = m_rmask[commit_ptr_i];
  rec.mem_wmask = m_wmask[commit_ptr_i];
  rec.mem_wdata = m_wdata[commit_ptr_i];
  rec.mem_rdata = commit_result_i;

  // Output buffer, a pop makes room for a push in the same cycle
  pop  = (m_expq.size() != 0) && trace_ready_i;
  full = m_expq.size() == FIFO_DEPTH;
  if (pop) m_expq.delete(0);
  if (push) begin
    if (!full || pop) begin
      m_expq.push_back(rec);
    end else begin
      m_overflow = 1'b1;
    end
  end

  // Issue write first, the LSU annotation lands on top of it
  if (dec_valid_i && dec_ack_i && !flush_unissued_i) begin
    m_instr[issue_ptr_i] = m_lat_word;
    m_rs1[issue_ptr_i]   = rs1_fwd_i;
    m_rs2[issue_ptr_i]   = rs2_fwd_i;
    m_addr[issue_ptr_i]  = '0;
    m_rmask[issue_ptr_i] = '0;
    m_wmask[issue_ptr_i] = '0;
    m_wdata[issue_ptr_i] = '0;
  end
  if (lsu_be_i != '0 && lsu_op_i == FU_LOAD) begin
    m_addr[lsu_trans_id_i]  = lsu_vaddr_i;
    m_rmask[lsu_trans_id_i] = lsu_be_i;
  end else if (lsu_be_i != '0 && lsu_op_i == FU_STORE) begin
    m_addr[lsu_trans_id_i]  = lsu_vaddr_i;
    m_wmask[lsu_trans_id_i] = lsu_be_i;
    m_wdata[lsu_trans_id_i] = lsu_wdata_i;
  end

  // Issue latch
  if (flush_i) begin
    m_lat_valid = 1'b0;
  end else if (fetch_valid_i && (!m_lat_valid || issue_ack_i)) begin
    m_lat_valid = 1'b1;
    m_lat_word  = fetch_compressed_i ? {16'b0, fetch_instr_i[15:0]} : fetch_instr_i;
  end else if (issue_ack_i) begin
    m_lat_valid = 1'b0;
  end
endtask

`endif

// File: testbench/tb_rvfi_tracer.sv
// Retirement tracer testbench
// Random probe traffic in phases, checked beat by beat against a model

module tb_rvfi_tracer;

  timeunit 1ns;
  timeprecision 100ps;

  import rvfi_pkg::*;

  localparam int LEN_ISSUE = 300;
  localparam int LEN_LSU   = 300;
  localparam int LEN_EXC   = 300;
  localparam int LEN_MODE  = 200;
  localparam int LEN_FILL  = 12;
  localparam int LEN_DRAIN = 10;
  localparam int LEN_POST  = 50;
  localparam int LEN_RESET = 3;     // Per reset, including the release edge
  localparam int TIMEOUT_CYCLES = LEN_ISSUE + LEN_LSU + LEN_EXC + LEN_MODE + LEN_FILL +
                                  LEN_DRAIN + LEN_POST + 2 * LEN_RESET + 50;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     fetch_valid_i, fetch_compressed_i, flush_i, issue_ack_i;
  logic [31:0]              fetch_instr_i;
  logic                     dec_valid_i, dec_ack_i, flush_unissued_i;
  logic [TRANS_ID_BITS-1:0] issue_ptr_i, lsu_trans_id_i, commit_ptr_i;
  logic [XLEN-1:0]          rs1_fwd_i, rs2_fwd_i, lsu_vaddr_i, lsu_wdata_i;
  fu_op_e                   lsu_op_i;
  logic [XLEN/8-1:0]        lsu_be_i;
  logic                     commit_valid_i, commit_ack_i, ex_valid_i, debug_mode_i;
  logic [XLEN-1:0]          commit_pc_i, commit_result_i, commit_wdata_i;
  logic [4:0]               commit_rs1_addr_i, commit_rs2_addr_i, commit_rd_addr_i;
  exc_cause_e               ex_cause_i;
  priv_lvl_e                priv_lvl_i;
  logic                     trace_ready_i;
  logic                     trace_valid_o, trace_retired_o, trace_trap_o, overflow_o;
  logic [4:0]               trace_cause_o, trace_rd_addr_o, trace_rs1_addr_o, trace_rs2_addr_o;
  logic [1:0]               trace_mode_o;
  logic [31:0]              trace_insn_o;
  logic [XLEN-1:0]          trace_pc_o, trace_rd_wdata_o, trace_rs1_rdata_o, trace_rs2_rdata_o;
  logic [XLEN-1:0]          trace_mem_addr_o, trace_mem_wdata_o, trace_mem_rdata_o;
  logic [XLEN/8-1:0]        trace_mem_rmask_o, trace_mem_wmask_o;

  // Traffic mix of the running phase, in percent
  int unsigned commit_pct, ack_pct, ex_pct, lsu_pct, ready_pct;
  logic        debug_on;
  string       test_name = "init";
  int          err_count = 0;
  int          cycle_cnt = 0;

  `include "tb_rvfi_model.svh"

  rvfi_tracer i_dut (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test phases did not finish", cycle_cnt);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic check_val(input string field, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      err_count++;
      $display("Fail %s %s: expected %h, actual %h", test_name, field, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch on %s", field);
    end
  endtask

  task automatic idle_inputs();
    {fetch_valid_i, fetch_compressed_i, flush_i, issue_ack_i} = '0;
    fetch_instr_i = '0;
    {dec_valid_i, dec_ack_i, flush_unissued_i} = '0;
    {issue_ptr_i, lsu_trans_id_i, commit_ptr_i} = '0;
    {rs1_fwd_i, rs2_fwd_i, lsu_vaddr_i, lsu_wdata_i} = '0;
    lsu_op_i = FU_NONE;
    lsu_be_i = '0;
    {commit_valid_i, commit_ack_i, ex_valid_i, debug_mode_i} = '0;
    {commit_pc_i, commit_result_i, commit_wdata_i} = '0;
    {commit_rs1_addr_i, commit_rs2_addr_i, commit_rd_addr_i} = '0;
    ex_cause_i    = CAUSE_ILLEGAL;
    priv_lvl_i    = PRIV_M;
    trace_ready_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus, driven on the falling edge
  // --------------------------------------------------------------------------
  task automatic drive_inputs();
    fetch_valid_i      = ($urandom % 100) < 60;
    fetch_instr_i      = $urandom;
    fetch_compressed_i = 1'($urandom);
    flush_i            = ($urandom % 100) < 8;
    issue_ack_i        = 1'($urandom);
    dec_valid_i        = ($urandom % 100) < 70;
    dec_ack_i          = ($urandom % 100) < 70;
    flush_unissued_i   = ($urandom % 100) < 10;
    issue_ptr_i        = 3'($urandom);
    rs1_fwd_i          = $urandom;
    rs2_fwd_i          = $urandom;
    lsu_trans_id_i     = 3'($urandom);
    lsu_vaddr_i        = $urandom;
    lsu_wdata_i        = $urandom;
    lsu_be_i           = (($urandom % 100) < lsu_pct) ? 4'($urandom) : 4'h0;
    case ($urandom % 3)
      0:       lsu_op_i = FU_NONE;
      1:       lsu_op_i = FU_LOAD;
      default: lsu_op_i = FU_STORE;
    endcase
    commit_valid_i     = ($urandom % 100) < commit_pct;
    commit_ack_i       = commit_valid_i && (($urandom % 100) < ack_pct);
    commit_ptr_i       = 3'($urandom);
    commit_pc_i        = $urandom;
    commit_rs1_addr_i  = 5'($urandom);
    commit_rs2_addr_i  = 5'($urandom);
    commit_rd_addr_i   = 5'($urandom);
    commit_result_i    = $urandom;
    commit_wdata_i     = $urandom;
    ex_valid_i         = ($urandom % 100) < ex_pct;
    case ($urandom % 5)
      0:       ex_cause_i = CAUSE_ILLEGAL;
      1:       ex_cause_i = CAUSE_BREAKPOINT;
      2:       ex_cause_i = CAUSE_ECALL_U;
      3:       ex_cause_i = CAUSE_ECALL_S;
      default: ex_cause_i = CAUSE_ECALL_M;
    endcase
    case ($urandom % 3)
      0:       priv_lvl_i = PRIV_U;
      1:       priv_lvl_i = PRIV_S;
      default: priv_lvl_i = PRIV_M;
    endcase
    debug_mode_i       = debug_on && 1'($urandom);
    trace_ready_i      = ($urandom % 100) < ready_pct;
  endtask

  // Outputs come from registers only, so they are stable here
  task automatic compare_outputs();
    trace_rec_t exp_rec;
    check_val("trace_valid", 32'(m_expq.size() != 0), 32'(trace_valid_o));
    check_val("overflow", 32'(m_overflow), 32'(overflow_o));
    if (trace_valid_o && trace_ready_i) begin
      exp_rec = m_expq[0];
      check_val("retired", 32'(exp_rec.retired), 32'(trace_retired_o));
      check_val("trap", 32'(exp_rec.trap), 32'(trace_trap_o));
      check_val("cause", 32'(exp_rec.cause), 32'(trace_cause_o));
      check_val("mode", 32'(exp_rec.mode), 32'(trace_mode_o));
      check_val("insn", exp_rec.insn, trace_insn_o);
      check_val("pc", exp_rec.pc, trace_pc_o);
      check_val("rd_addr", 32'(exp_rec.rd_addr), 32'(trace_rd_addr_o));
      check_val("rd_wdata", exp_rec.rd_wdata, trace_rd_wdata_o);
      check_val("rs1_addr", 32'(exp_rec.rs1_addr), 32'(trace_rs1_addr_o));
      check_val("rs2_addr", 32'(exp_rec.rs2_addr), 32'(trace_rs2_addr_o));
      check_val("rs1_rdata", exp_rec.rs1_rdata, trace_rs1_rdata_o);
      check_val("rs2_rdata", exp_rec.rs2_rdata, trace_rs2_rdata_o);
      check_val("mem_addr", exp_rec.mem_addr, trace_mem_addr_o);
      check_val("mem_rmask", 32'(exp_rec.mem_rmask), 32'(trace_mem_rmask_o));
      check_val("mem_wmask", 32'(exp_rec.mem_wmask), 32'(trace_mem_wmask_o));
      check_val("mem_wdata", exp_rec.mem_wdata, trace_mem_wdata_o);
      check_val("mem_rdata", exp_rec.mem_rdata, trace_mem_rdata_o);
    end
  endtask

  task automatic run_phase(input string name, input int cycles);
    test_name = name;
    repeat (cycles) begin
      @(negedge clk_i);
      drive_inputs();
      compare_outputs();
      model_step();             // Mirrors the coming rising edge
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    idle_inputs();
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    model_reset();
    test_name = "reset";
    check_val("trace_valid", 32'h0, 32'(trace_valid_o));
    check_val("overflow", 32'h0, 32'(overflow_o));
  endtask

  initial begin
    void'($urandom(65));
    rst_ni = 1'b0;
    idle_inputs();
    apply_reset();

    commit_pct = 40;
    ack_pct    = 80;
    ex_pct     = 0;
    lsu_pct    = 0;
    ready_pct  = 90;
    debug_on   = 1'b0;
    run_phase("fetch_issue", LEN_ISSUE);

    lsu_pct = 60;
    run_phase("lsu_annotate", LEN_LSU);

    commit_pct = 60;
    ex_pct     = 50;
    run_phase("exceptions", LEN_EXC);

    ex_pct   = 20;
    debug_on = 1'b1;
    run_phase("priv_mode", LEN_MODE);

    // Stall the stream past the buffer depth, then drain it
    commit_pct = 100;
    ack_pct    = 100;
    ex_pct     = 0;
    ready_pct  = 0;
    run_phase("overflow_fill", LEN_FILL);
    check_val("overflow_set", 32'h1, 32'(overflow_o));
    commit_pct = 0;
    ready_pct  = 100;
    run_phase("overflow_drain", LEN_DRAIN);
    check_val("buffer_drained", 32'h0, 32'(trace_valid_o));

    apply_reset();
    commit_pct = 50;
    ready_pct  = 70;
    run_phase("post_reset", LEN_POST);

    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+testbench
design/rvfi_pkg.sv
design/rvfi_issue_latch.sv
design/rvfi_shadow_table.sv
design/rvfi_commit_pack.sv
design/rvfi_trace_fifo.sv
design/rvfi_tracer.sv
testbench/tb_rvfi_tracer.sv
